// ==== rs5_core.f ====
+incdir+verif
common/rs5_pkg.sv
src/regbank.sv
fetch/fetch.sv
decode/decode.sv
execute/execute.sv
src/retire.sv
src/rs5_core.sv
verif/rs5_core_tb.sv

// ==== verif/rs5_core_model.svh ====
/*
 * Instruction-set model and random helpers for the core testbench.
 * Included inside the testbench module after its program and queue
 * declarations. Runs the program on private registers and memory.
 */
`ifndef RS5_CORE_MODEL_SVH
`define RS5_CORE_MODEL_SVH

// LCG state, also read by the stall driver
logic [31:0] rand_state = 32'h59b18e2e;

function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    // Fold high bits down, the low LCG bits repeat quickly
    return rand_state ^ (rand_state >> 16);
endfunction

// Initial data memory contents, a hash of the byte address
function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return (addr * 32'h9e3779b1) ^ 32'ha5c3_0f96;
endfunction

function automatic logic [31:0] lane_mask(input logic [3:0] strobe);
    return {{8{strobe[3]}}, {8{strobe[2]}}, {8{strobe[1]}}, {8{strobe[0]}}};
endfunction

// RV32I integer ops by funct3, alt selects SUB and SRA
function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        3'd3: return (a < b) ? 32'd1 : 32'd0;
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) begin
                return $signed(a) >>> b[4:0];
            end
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

task automatic run_model();
    logic [31:0] mregs [0:31];
    logic [31:0] mmem [0:DMEM_WORDS-1];
    logic [31:0] ins, a, b, imm, ea, word, val;
    logic [2:0]  f3;
    logic [3:0]  strobe;
    foreach (mregs[r]) mregs[r] = '0;
    foreach (mmem[w]) mmem[w] = fill_word(32'(w) << 2);
    for (int i = 0; i < NUM_INSTR; i++) begin
        ins = prog[i];
        f3  = ins[14:12];
        a   = mregs[ins[19:15]];
        b   = mregs[ins[24:20]];
        imm = {{20{ins[31]}}, ins[31:20]};
        case (ins[6:0])
            rs5_pkg::OPC_OP:     mregs[ins[11:7]] = alu_result(f3, ins[30], a, b);
            rs5_pkg::OPC_OP_IMM: mregs[ins[11:7]] = alu_result(f3, ins[30] && f3 == 3'd5, a, imm);
            rs5_pkg::OPC_LUI:    mregs[ins[11:7]] = {ins[31:12], 12'b0};
            rs5_pkg::OPC_LOAD: begin
                ea   = a + imm;
                word = mmem[(ea >> 2) % DMEM_WORDS] >> (8 * ea[1:0]);
                case (f3)
                    3'd0:    val = {{24{word[7]}}, word[7:0]};
                    3'd1:    val = {{16{word[15]}}, word[15:0]};
                    3'd4:    val = {24'b0, word[7:0]};
                    3'd5:    val = {16'b0, word[15:0]};
                    default: val = word;
                endcase
                mregs[ins[11:7]] = val;
                expected.push_back('{addr: ea, wdata: '0, strobe: 4'b0000, read: 1'b1});
            end
            rs5_pkg::OPC_STORE: begin
                ea     = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                strobe = (f3 == 3'd0) ? 4'b0001 : (f3 == 3'd1) ? 4'b0011 : 4'b1111;
                strobe = strobe << ea[1:0];
                // Value moved up to its lane, other bytes cleared
                val    = (b << (8 * ea[1:0])) & lane_mask(strobe);
                mmem[(ea >> 2) % DMEM_WORDS] =
                    (mmem[(ea >> 2) % DMEM_WORDS] & ~lane_mask(strobe)) | val;
                expected.push_back('{addr: ea, wdata: val, strobe: strobe, read: 1'b0});
            end
            default: ;
        endcase
        mregs[0] = '0;
    end
endtask

`endif

// ==== verif/rs5_core_tb.sv ====
/*
 * Testbench for the core. Runs a random program from a synchronous
 * instruction memory under random stall, answers the data port like a
 * synchronous memory and checks every accepted request against a model.
 */
`timescale 1ns/100ps

module rs5_core_tb;

    localparam int NUM_INSTR      = 200;
    localparam int DMEM_WORDS     = 128;
    localparam int DUMP_BASE      = 256;
    localparam int TIMEOUT_CYCLES = 10 + 3 * NUM_INSTR + 50;
    localparam int DRAIN_CYCLES   = 20;

    logic                     clk = 1'b0;
    logic                     rst_i;
    logic                     stall_i;
    logic [rs5_pkg::XLEN-1:0] instruction_i;
    logic [rs5_pkg::XLEN-1:0] mem_data_i;
    logic [rs5_pkg::XLEN-1:0] instruction_address_o;
    logic                     mem_operation_enable_o;
    logic [3:0]               mem_write_enable_o;
    logic [rs5_pkg::XLEN-1:0] mem_address_o;
    logic [rs5_pkg::XLEN-1:0] mem_data_o;

    logic [31:0]              prog [0:NUM_INSTR-1];
    logic [31:0]              dmem [0:DMEM_WORDS-1];
    rs5_pkg::mem_req_t        expected [$];
    int unsigned              seen = 0;
    int unsigned              errors = 0;
    int unsigned              cycle_count = 0;

    `include "rs5_core_model.svh"

    always #50 clk = ~clk;

    rs5_core rs5_core_inst (
        .clk                    (clk),
        .rst_i                  (rst_i),
        .stall_i                (stall_i),
        .instruction_i          (instruction_i),
        .mem_data_i             (mem_data_i),
        .instruction_address_o  (instruction_address_o),
        .mem_operation_enable_o (mem_operation_enable_o),
        .mem_write_enable_o     (mem_write_enable_o),
        .mem_address_o          (mem_address_o),
        .mem_data_o             (mem_data_o)
    );

    task automatic report_mismatch(input string name, input logic [31:0] want,
                                   input logic [31:0] got);
        errors++;
        $display("mismatch at %0t: %s expected %h, got %h", $time, name, want, got);
    endtask

    function automatic logic [31:0] encode_store(input logic [2:0] f3, input logic [4:0] rs2,
                                                 input logic [11:0] off);
        return {off[11:5], rs2, 5'd0, f3, off[4:0], rs5_pkg::OPC_STORE};
    endfunction

    // One legal instruction on x0..x7, memory ops on x0 plus an aligned offset
    function automatic logic [31:0] random_instr();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [4:0]  rd, rs1, rs2;
        logic [11:0] off;
        r   = next_rand();
        f3  = r[10:8];
        rd  = {2'b0, r[13:11]};
        rs1 = {2'b0, r[16:14]};
        rs2 = {2'b0, r[19:17]};
        case (r[2:0])
            3'd0, 3'd1:
                return {((f3 == 3'd0 || f3 == 3'd5) && r[21]) ? 7'h20 : 7'h00,
                        rs2, rs1, f3, rd, rs5_pkg::OPC_OP};
            3'd2, 3'd3: begin
                off = r[31:20];
                // Shift forms keep funct7 legal
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    off = {(f3 == 3'd5 && r[25]) ? 7'h20 : 7'h00, r[24:20]};
                end
                return {off, rs1, f3, rd, rs5_pkg::OPC_OP_IMM};
            end
            3'd4:
                return {r[31:12], rd, rs5_pkg::OPC_LUI};
            3'd5: begin
                if (f3 == 3'd3 || f3 >= 3'd6) begin
                    f3 = 3'd2;
                end
                off = ({4'b0, r[27:20]} >> f3[1:0]) << f3[1:0];
                return {off, 5'd0, f3, rd, rs5_pkg::OPC_LOAD};
            end
            default: begin
                f3 = {1'b0, r[9:8]};
                if (f3 == 3'd3) begin
                    f3 = 3'd2;
                end
                off = ({4'b0, r[27:20]} >> f3[1:0]) << f3[1:0];
                return encode_store(f3, rs2, off);
            end
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Memories and stall
    ////////////////////////////////////////////////////////////////////////////

    // Word one clock after the address, NOP past the program
    always @(posedge clk) begin
        if (instruction_address_o < NUM_INSTR * 4) begin
            instruction_i <= prog[instruction_address_o >> 2];
        end else begin
            instruction_i <= rs5_pkg::NOP_INSTR;
        end
    end

    // Roughly one stalled cycle in four
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (rst_i) begin
            stall_i <= 1'b0;
        end else begin
            stall_i <= (next_rand() & 32'd3) == 32'd0;
        end
    end

    // Accepted request, compare in order then serve it
    always @(posedge clk) begin : data_port
        rs5_pkg::mem_req_t want;
        logic [31:0]       mask;
        mask = lane_mask(mem_write_enable_o);
        if (!rst_i && mem_operation_enable_o && !stall_i) begin
            if (seen >= expected.size()) begin
                errors++;
                $display("Error at %0t: extra data request to address %h", $time, mem_address_o);
            end else begin
                want = expected[seen];
                assert (mem_address_o == want.addr)
                    else report_mismatch("mem_address_o", want.addr, mem_address_o);
                assert (mem_write_enable_o == want.strobe)
                    else report_mismatch("mem_write_enable_o", want.strobe, mem_write_enable_o);
                assert ((mem_data_o & mask) == want.wdata)
                    else report_mismatch("mem_data_o", want.wdata, mem_data_o & mask);
            end
            seen <= seen + 1;
            if (mem_write_enable_o != 4'b0000) begin
                dmem[(mem_address_o >> 2) % DMEM_WORDS] <=
                    (dmem[(mem_address_o >> 2) % DMEM_WORDS] & ~mask) | (mem_data_o & mask);
            end else begin
                mem_data_i <= dmem[(mem_address_o >> 2) % DMEM_WORDS];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        rst_i         = 1'b1;
        stall_i       = 1'b0;
        instruction_i = rs5_pkg::NOP_INSTR;
        mem_data_i    = '0;
        // Random body, then x0..x7 dumped above the random data area
        for (int i = 0; i < NUM_INSTR; i++) begin
            if (i >= NUM_INSTR - 8) begin
                prog[i] = encode_store(3'd2, 5'(i - (NUM_INSTR - 8)),
                                       12'(DUMP_BASE + 4 * (i - (NUM_INSTR - 8))));
            end else begin
                prog[i] = random_instr();
            end
        end
        foreach (dmem[w]) dmem[w] = fill_word(32'(w) << 2);
        run_model();

        repeat (10) @(posedge clk);
        rst_i <= 1'b0;
        // Middle of the first cycle out of reset
        @(negedge clk);
        assert (instruction_address_o == rs5_pkg::RESET_ADDR)
            else report_mismatch("instruction_address_o", rs5_pkg::RESET_ADDR,
                                 instruction_address_o);
        assert (!mem_operation_enable_o)
            else report_mismatch("mem_operation_enable_o", 32'd0, 32'(mem_operation_enable_o));
        assert (mem_write_enable_o == 4'b0000)
            else report_mismatch("mem_write_enable_o", 32'd0, 32'(mem_write_enable_o));

        while (seen < expected.size() && cycle_count < TIMEOUT_CYCLES) begin
            @(negedge clk);
        end
        if (seen < expected.size()) begin
            errors++;
            $display("Error: run did not finish in %0d cycles, %0d of %0d requests seen",
                     TIMEOUT_CYCLES, seen, expected.size());
        end else begin
            // Catch requests beyond the program
            repeat (DRAIN_CYCLES) @(negedge clk);
        end

        $display("Requests: %0d seen, %0d expected; error count: %0d",
                 seen, expected.size(), errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== src/rs5_core.sv ====
/*
 * Top level of the cut-down RS5 core.
 * Wires fetch, decode, register bank, execute and retire, and maps the
 * execute request onto a synchronous data memory with a global stall.
 */
`timescale 1ns/100ps

module rs5_core (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     stall_i,
    input  logic [rs5_pkg::XLEN-1:0] instruction_i,
    input  logic [rs5_pkg::XLEN-1:0] mem_data_i,
    output logic [rs5_pkg::XLEN-1:0] instruction_address_o,
    output logic                     mem_operation_enable_o,
    output logic [3:0]               mem_write_enable_o,
    output logic [rs5_pkg::XLEN-1:0] mem_address_o,
    output logic [rs5_pkg::XLEN-1:0] mem_data_o
);

    ////////////////////////////////////////////////////////////////////////////
    // Stage signals
    ////////////////////////////////////////////////////////////////////////////

    logic                           hazard;
    logic                           enable_fetch;
    logic                           enable_pipe;

    rs5_pkg::fetch_t                fetch_data;
    logic                           fetch_valid;

    logic [rs5_pkg::REG_ADDR_W-1:0] rs1, rs2;
    logic [rs5_pkg::XLEN-1:0]       rs1_data, rs2_data;

    rs5_pkg::exec_t                 exec_data;
    logic [rs5_pkg::REG_ADDR_W-1:0] exec_rd;
    logic                           exec_we;

    rs5_pkg::retire_t               retire_data;
    rs5_pkg::mem_req_t              mem_req;

    logic [rs5_pkg::REG_ADDR_W-1:0] wb_rd;
    logic [rs5_pkg::XLEN-1:0]       wb_data;
    logic                           wb_we;
    logic                           wb_we_gated;

    // Stall freezes everything, a hazard only the front end
    assign enable_fetch = !(stall_i || hazard);
    assign enable_pipe  = !stall_i;

    // No register write while the pipe is frozen
    assign wb_we_gated = wb_we && !stall_i;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline
    ////////////////////////////////////////////////////////////////////////////

    fetch fetch1 (
        .clk                   (clk),
        .rst_i                 (rst_i),
        .enable_i              (enable_fetch),
        .instruction_i         (instruction_i),
        .fetch_o               (fetch_data),
        .valid_o               (fetch_valid),
        .instruction_address_o (instruction_address_o)
    );

    decode decoder1 (
        .clk        (clk),
        .rst_i      (rst_i),
        .enable_i   (enable_pipe),
        .fetch_i    (fetch_data),
        .valid_i    (fetch_valid),
        .rs1_o      (rs1),
        .rs2_o      (rs2),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .exec_rd_i  (exec_rd),
        .exec_we_i  (exec_we),
        .exec_o     (exec_data),
        .hazard_o   (hazard)
    );

    regbank regbank1 (
        .clk     (clk),
        .rst_i   (rst_i),
        .rs1_i   (rs1),
        .rs2_i   (rs2),
        .rd_i    (wb_rd),
        .we_i    (wb_we_gated),
        .data_i  (wb_data),
        .data1_o (rs1_data),
        .data2_o (rs2_data)
    );

    execute execute1 (
        .clk       (clk),
        .rst_i     (rst_i),
        .enable_i  (enable_pipe),
        .exec_i    (exec_data),
        .mem_req_o (mem_req),
        .retire_o  (retire_data),
        .rd_o      (exec_rd),
        .we_o      (exec_we)
    );

    retire retire1 (
        .retire_i   (retire_data),
        .mem_data_i (mem_data_i),
        .rd_o       (wb_rd),
        .we_o       (wb_we),
        .data_o     (wb_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Data memory port
    ////////////////////////////////////////////////////////////////////////////

    assign mem_operation_enable_o = (mem_req.strobe != '0) || mem_req.read;
    assign mem_write_enable_o     = mem_req.strobe;
    assign mem_address_o          = mem_req.addr;
    assign mem_data_o             = mem_req.wdata;

endmodule

// ==== src/retire.sv ====
/*
 * Retire stage. Picks the loaded byte or half out of the memory word
 * and extends it, otherwise passes the ALU result to write-back.
 */
`timescale 1ns/100ps

module retire (
    input  rs5_pkg::retire_t               retire_i,
    input  logic [rs5_pkg::XLEN-1:0]       mem_data_i,
    output logic [rs5_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                           we_o,
    output logic [rs5_pkg::XLEN-1:0]       data_o
);

    logic [7:0]               byte_sel;
    logic [15:0]              half_sel;
    logic [rs5_pkg::XLEN-1:0] load_data;

    always_comb begin
        // Lane by low address bits
        byte_sel = mem_data_i[{retire_i.addr_lo, 3'b000} +: 8];
        half_sel = retire_i.addr_lo[1] ? mem_data_i[31:16] : mem_data_i[15:0];
        case (retire_i.size)
            rs5_pkg::SIZE_BYTE:
                load_data = {{(rs5_pkg::XLEN-8){retire_i.sign && byte_sel[7]}}, byte_sel};
            rs5_pkg::SIZE_HALF:
                load_data = {{(rs5_pkg::XLEN-16){retire_i.sign && half_sel[15]}}, half_sel};
            default:
                load_data = mem_data_i;
        endcase
    end

    assign data_o = retire_i.load ? load_data : retire_i.result;
    assign rd_o   = retire_i.rd;
    assign we_o   = retire_i.we;

endmodule

// ==== execute/execute.sv ====
/*
 * Execute stage. ALU and address adder on the decode register,
 * combinational data memory request with lane-replicated store data,
 * and the register feeding retire.
 */
`timescale 1ns/100ps

module execute (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           enable_i,
    input  rs5_pkg::exec_t                 exec_i,
    output rs5_pkg::mem_req_t              mem_req_o,
    output rs5_pkg::retire_t               retire_o,
    output logic [rs5_pkg::REG_ADDR_W-1:0] rd_o,
    output logic                           we_o
);

    logic [rs5_pkg::XLEN-1:0] sum;
    logic [rs5_pkg::XLEN-1:0] result;
    logic [4:0]               shamt;

    // Also the load/store address
    assign sum   = exec_i.op1 + exec_i.op2;
    assign shamt = exec_i.op2[4:0];

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (exec_i.op)
            rs5_pkg::OP_ADD:  result = sum;
            rs5_pkg::OP_SUB:  result = exec_i.op1 - exec_i.op2;
            rs5_pkg::OP_SLL:  result = exec_i.op1 << shamt;
            rs5_pkg::OP_SLT:  result = {{(rs5_pkg::XLEN-1){1'b0}},
                                        $signed(exec_i.op1) < $signed(exec_i.op2)};
            rs5_pkg::OP_SLTU: result = {{(rs5_pkg::XLEN-1){1'b0}}, exec_i.op1 < exec_i.op2};
            rs5_pkg::OP_XOR:  result = exec_i.op1 ^ exec_i.op2;
            rs5_pkg::OP_SRL:  result = exec_i.op1 >> shamt;
            rs5_pkg::OP_SRA:  result = $signed(exec_i.op1) >>> shamt;
            rs5_pkg::OP_OR:   result = exec_i.op1 | exec_i.op2;
            rs5_pkg::OP_AND:  result = exec_i.op1 & exec_i.op2;
            // Upper immediate already shifted in decode
            rs5_pkg::OP_LUI:  result = exec_i.op2;
            default:          result = sum;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        mem_req_o.addr = sum;
        mem_req_o.read = (exec_i.op == rs5_pkg::OP_LOAD);
        // Data copied into every lane, strobe picks the live one
        case (exec_i.size)
            rs5_pkg::SIZE_BYTE: begin
                mem_req_o.wdata  = {4{exec_i.store_data[7:0]}};
                mem_req_o.strobe = 4'b0001 << sum[1:0];
            end
            rs5_pkg::SIZE_HALF: begin
                mem_req_o.wdata  = {2{exec_i.store_data[15:0]}};
                mem_req_o.strobe = 4'b0011 << {sum[1], 1'b0};
            end
            default: begin
                mem_req_o.wdata  = exec_i.store_data;
                mem_req_o.strobe = 4'b1111;
            end
        endcase
        if (exec_i.op != rs5_pkg::OP_STORE) begin
            mem_req_o.strobe = 4'b0000;
        end
    end

    // Seen by decode for the hazard check
    assign rd_o = exec_i.rd;
    assign we_o = exec_i.we;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            retire_o.we   <= 1'b0;
            retire_o.load <= 1'b0;
        end else if (enable_i) begin
            retire_o.result  <= result;
            retire_o.rd      <= exec_i.rd;
            retire_o.we      <= exec_i.we;
            retire_o.load    <= (exec_i.op == rs5_pkg::OP_LOAD);
            retire_o.size    <= exec_i.size;
            retire_o.sign    <= exec_i.sign;
            retire_o.addr_lo <= sum[1:0];
        end
    end

endmodule

// ==== decode/decode.sv ====
/*
 * Decode stage. Cracks the instruction into an operation, builds the
 * immediates, reads operands and registers the execute payload.
 * Stalls fetch for one cycle when a source is written in execute.
 */
`timescale 1ns/100ps

module decode (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic                           enable_i,
    input  rs5_pkg::fetch_t                fetch_i,
    input  logic                           valid_i,
    output logic [rs5_pkg::REG_ADDR_W-1:0] rs1_o,
    output logic [rs5_pkg::REG_ADDR_W-1:0] rs2_o,
    input  logic [rs5_pkg::XLEN-1:0]       rs1_data_i,
    input  logic [rs5_pkg::XLEN-1:0]       rs2_data_i,
    input  logic [rs5_pkg::REG_ADDR_W-1:0] exec_rd_i,
    input  logic                           exec_we_i,
    output rs5_pkg::exec_t                 exec_o,
    output logic                           hazard_o
);

    logic [31:0]              raw_instr;
    logic [31:0]              instr;
    logic [6:0]               raw_opcode;
    logic                     uses_rs1;
    logic                     uses_rs2;
    logic [6:0]               opcode;
    logic [2:0]               funct3;
    logic [rs5_pkg::XLEN-1:0] imm_i, imm_s, imm_u;
    rs5_pkg::exec_t           exec_d;

    // Shared funct3 map of register and immediate ALU forms
    function automatic rs5_pkg::op_e alu_op(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_op = alt ? rs5_pkg::OP_SUB : rs5_pkg::OP_ADD;
            3'b001:  alu_op = rs5_pkg::OP_SLL;
            3'b010:  alu_op = rs5_pkg::OP_SLT;
            3'b011:  alu_op = rs5_pkg::OP_SLTU;
            3'b100:  alu_op = rs5_pkg::OP_XOR;
            3'b101:  alu_op = alt ? rs5_pkg::OP_SRA : rs5_pkg::OP_SRL;
            3'b110:  alu_op = rs5_pkg::OP_OR;
            default: alu_op = rs5_pkg::OP_AND;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Register read and hazard check
    ////////////////////////////////////////////////////////////////////////////

    // Nothing valid from fetch yet
    assign raw_instr  = valid_i ? fetch_i.instr : rs5_pkg::NOP_INSTR;
    assign raw_opcode = raw_instr[6:0];
    assign rs1_o      = raw_instr[19:15];
    assign rs2_o      = raw_instr[24:20];

    assign uses_rs1 = raw_opcode inside {rs5_pkg::OPC_OP, rs5_pkg::OPC_OP_IMM,
                                         rs5_pkg::OPC_LOAD, rs5_pkg::OPC_STORE};
    assign uses_rs2 = raw_opcode inside {rs5_pkg::OPC_OP, rs5_pkg::OPC_STORE};

    // Producer in execute writes back a cycle late for the bank
    assign hazard_o = exec_we_i && (exec_rd_i != '0)
                      && ((uses_rs1 && rs1_o == exec_rd_i)
                      ||  (uses_rs2 && rs2_o == exec_rd_i));

    // Bubble goes down, the instruction stays in fetch
    assign instr  = hazard_o ? rs5_pkg::NOP_INSTR : raw_instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    // I, S and U immediates
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_u = {instr[31:12], 12'b0};

    ////////////////////////////////////////////////////////////////////////////
    // Operation and operand select
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        exec_d            = '0;
        exec_d.op         = rs5_pkg::OP_NOP;
        exec_d.op1        = rs1_data_i;
        exec_d.op2        = imm_i;
        exec_d.store_data = rs2_data_i;
        exec_d.rd         = instr[11:7];
        exec_d.size       = rs5_pkg::SIZE_WORD;
        exec_d.sign       = !funct3[2];
        case (opcode)
            rs5_pkg::OPC_OP: begin
                exec_d.op  = alu_op(funct3, instr[30]);
                exec_d.op2 = rs2_data_i;
                exec_d.we  = 1'b1;
            end
            rs5_pkg::OPC_OP_IMM: begin
                // Only shifts use bit 30 in the immediate form
                exec_d.op = alu_op(funct3, funct3 == 3'b101 && instr[30]);
                exec_d.we = 1'b1;
            end
            rs5_pkg::OPC_LUI: begin
                exec_d.op  = rs5_pkg::OP_LUI;
                exec_d.op2 = imm_u;
                exec_d.we  = 1'b1;
            end
            rs5_pkg::OPC_LOAD: begin
                // LB LH LW LBU LHU
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    exec_d.op   = rs5_pkg::OP_LOAD;
                    exec_d.size = rs5_pkg::mem_size_e'(funct3[1:0]);
                    exec_d.we   = 1'b1;
                end
            end
            rs5_pkg::OPC_STORE: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    exec_d.op   = rs5_pkg::OP_STORE;
                    exec_d.op2  = imm_s;
                    exec_d.size = rs5_pkg::mem_size_e'(funct3[1:0]);
                end
            end
            default: ;
        endcase
        // x0 is never a target
        exec_d.we = exec_d.we && (exec_d.rd != '0);
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            exec_o.op <= rs5_pkg::OP_NOP;
            exec_o.we <= 1'b0;
        end else if (enable_i) begin
            exec_o <= exec_d;
        end
    end

endmodule

// ==== fetch/fetch.sv ====
/*
 * Fetch stage. Presents the next instruction address to a synchronous
 * memory and pairs the returning word with its address for decode.
 * A held copy of the word covers cycles in which the PC was frozen.
 */
`timescale 1ns/100ps

module fetch (
    input  logic                     clk,
    input  logic                     rst_i,
    input  logic                     enable_i,
    input  logic [rs5_pkg::XLEN-1:0] instruction_i,
    output rs5_pkg::fetch_t          fetch_o,
    output logic                     valid_o,
    output logic [rs5_pkg::XLEN-1:0] instruction_address_o
);

    // Next address, and address of the word now arriving
    logic [rs5_pkg::XLEN-1:0] pc_q;
    logic [rs5_pkg::XLEN-1:0] addr_q;
    // Word shown last cycle, replayed after a frozen cycle
    logic [31:0]              held_instr_q;
    logic                     held_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            pc_q    <= rs5_pkg::RESET_ADDR;
            addr_q  <= rs5_pkg::RESET_ADDR;
            valid_o <= 1'b0;
            held_q  <= 1'b0;
        end else begin
            // First word is back one clock after reset
            valid_o <= 1'b1;
            // Memory moves on to pc_q, decode still wants addr_q
            held_q  <= valid_o && !enable_i;
            if (enable_i) begin
                pc_q   <= pc_q + rs5_pkg::INSTR_BYTES;
                addr_q <= pc_q;
            end
        end
    end

    always_ff @(posedge clk) begin
        held_instr_q <= fetch_o.instr;
    end

    assign instruction_address_o = pc_q;
    assign fetch_o.pc            = addr_q;
    assign fetch_o.instr         = held_q ? held_instr_q : instruction_i;

endmodule

// ==== src/regbank.sv ====
/*
 * General register bank, x1 to x31 in flip-flops.
 * Two combinational read ports; a write in the same cycle to the
 * same index is forwarded so decode sees the retiring value.
 */
`timescale 1ns/100ps

module regbank (
    input  logic                           clk,
    input  logic                           rst_i,
    input  logic [rs5_pkg::REG_ADDR_W-1:0] rs1_i,
    input  logic [rs5_pkg::REG_ADDR_W-1:0] rs2_i,
    input  logic [rs5_pkg::REG_ADDR_W-1:0] rd_i,
    input  logic                           we_i,
    input  logic [rs5_pkg::XLEN-1:0]       data_i,
    output logic [rs5_pkg::XLEN-1:0]       data1_o,
    output logic [rs5_pkg::XLEN-1:0]       data2_o
);

    // No storage behind x0
    logic [rs5_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && rd_i != '0) begin
            regs[rd_i] <= data_i;
        end
    end

    // Read ports with write-through
    always_comb begin
        data1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
        data2_o = (rs2_i == '0) ? '0 : regs[rs2_i];
        if (we_i && rs1_i != '0 && rs1_i == rd_i) begin
            data1_o = data_i;
        end
        if (we_i && rs2_i != '0 && rs2_i == rd_i) begin
            data2_o = data_i;
        end
    end

endmodule

// ==== common/rs5_pkg.sv ====
/*
 * Shared definitions for the cut-down RS5 integer pipeline.
 * Widths, major opcodes, the decoded operation and the structs
 * that travel between stages. Compile ahead of every RTL file.
 */
package rs5_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and fixed values
    ////////////////////////////////////////////////////////////////////////////

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    // First fetch address and PC step
    localparam logic [XLEN-1:0] RESET_ADDR  = 32'h0000_0000;
    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

    // Bubble word, ADDI x0, x0, 0
    localparam logic [31:0] NOP_INSTR = 32'h0000_0013;

    // Major opcodes still decoded
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    ////////////////////////////////////////////////////////////////////////////
    // Enumerations
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR,
        OP_SRL, OP_SRA, OP_OR, OP_AND, OP_LUI, OP_LOAD, OP_STORE
    } op_e;

    // Same coding as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

    ////////////////////////////////////////////////////////////////////////////
    // Stage payloads
    ////////////////////////////////////////////////////////////////////////////

    // Fetch to decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } fetch_t;

    // Decode to execute
    typedef struct packed {
        op_e                   op;
        logic [XLEN-1:0]       op1;
        logic [XLEN-1:0]       op2;
        logic [XLEN-1:0]       store_data;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        mem_size_e             size;
        logic                  sign;
    } exec_t;

    // Execute to retire
    typedef struct packed {
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] rd;
        logic                  we;
        logic                  load;
        mem_size_e             size;
        logic                  sign;
        logic [1:0]            addr_lo;
    } retire_t;

    // Data memory request, strobe of zero means no store
    typedef struct packed {
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
        logic [3:0]      strobe;
        logic            read;
    } mem_req_t;

endpackage
